// ==== tb.f ====
+incdir+verilog
verilog/um_pkg.sv
verilog/cfg_dispatch.sv
verilog/pkt_parser.sv
verilog/key_builder.sv
verilog/action_stage.sv
verilog/pkt_output.sv
verilog/um_top.sv
testbench/tb_um.sv

// ==== Makefile ====
# Verilator build and run of the packet pipeline testbench

TOP := tb_um

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== testbench/tb_um.sv ====
//************************************************************
// testbench for the packet pipeline top level
// acts as packet source and sink, match engine and localbus host,
// and checks keys, packets and config readback against a model
//************************************************************
`include "um_cfg.svh"

module tb_um;

    localparam int     CLK_PERIOD    = 10;
    localparam integer SEED          = 32'hdc50;
    localparam int     N_PHASE       = 3;
    localparam int     PKT_PER_PHASE = 40;
    localparam int     MAX_LEN       = 6;
    localparam int     CFG_PER_PHASE = 2 + 2 * `UM_ACT_DEPTH;
    localparam int     CYC_PER_FLIT  = 20;
    localparam int     CYC_PER_CFG   = 30;
    localparam int     DRAIN_CYC     = 200;
    // watchdog budget from packet count, packet length and config count
    localparam int     WD_CYCLES     = 20 + N_PHASE * (PKT_PER_PHASE * MAX_LEN * CYC_PER_FLIT
                                       + (CFG_PER_PHASE + 1) * CYC_PER_CFG + DRAIN_CYC);
    localparam logic [15:0] KEY_ADDR = {`UM_SEL_KEY, 13'd0};
    localparam logic [15:0] BAD_ADDR = {3'b111, 13'd0};
    localparam logic [2:0]  PHASE_MASK [N_PHASE] = '{3'b111, 3'b001, 3'b110};

    logic                  clk = 1'b0;
    logic                  rst_n;
    um_pkg::flit_t         pktin_data;
    logic                  pktin_data_wr;
    logic                  pktin_ready;
    um_pkg::flit_t         pktout_data;
    logic                  pktout_data_wr;
    logic                  pktout_ready;
    um_pkg::lookup_key_t   match_key;
    logic                  match_key_wr;
    logic                  match_ready;
    logic [`UM_ID_W-1:0]   match_id;
    logic                  match_id_wr;
    logic                  match_alf;
    logic                  ctrl_cs_n;
    logic                  ctrl_cmd;
    logic [31:0]           ctrl_addr;
    logic [31:0]           ctrl_datain;
    logic                  um2ctrl_ack_n;
    logic [31:0]           ctrl_dataout;

    // separate random streams per process, all from the one seed
    integer seed_pkt = SEED;
    integer seed_bp  = SEED ^ 32'h1;
    integer seed_rsp = SEED ^ 32'h2;

    logic bp_en      = 1'b0;
    logic ready_prev = 1'b1;
    int   rx_cnt     = 0;
    int   exp_total  = 0;

    // reference model state
    logic [2:0]          mask_m;
    um_pkg::act_entry_t  tbl_m [`UM_ACT_DEPTH];
    um_pkg::lookup_key_t exp_key_q [$];
    um_pkg::flit_t       exp_flit_q [$];
    um_pkg::lookup_key_t rsp_key_q [$];

    um_top u_um_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    //************************************************************
    // reporting
    //************************************************************
    task automatic check_value(input string name, input logic [159:0] got,
                               input logic [159:0] exp);
        if (got !== exp) begin
            $display("Fail time=%0t %s got %0h expected %0h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s at time %0t", what, $time);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_reset_outputs(input logic in_reset);
        check_value("pktout_data_wr", 160'(pktout_data_wr), 160'(1'b0));
        check_value("match_key_wr", 160'(match_key_wr), 160'(1'b0));
        check_value("um2ctrl_ack_n", 160'(um2ctrl_ack_n), 160'(1'b1));
        if (in_reset) begin
            check_value("pktin_ready", 160'(pktin_ready), 160'(1'b0));
            check_value("match_alf", 160'(match_alf), 160'(1'b0));
        end
    endtask

    //************************************************************
    // localbus host
    //************************************************************
    task automatic cfg_access(input logic rw, input logic [15:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        @(negedge clk);
        ctrl_cs_n   = 1'b0;
        ctrl_cmd    = rw;
        ctrl_addr   = {16'd0, addr};
        ctrl_datain = wdata;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (um2ctrl_ack_n);
        if (n < 5) begin
            abort_run("localbus ack came sooner than five cycles after chip select");
        end
        rdata     = ctrl_dataout;
        ctrl_cs_n = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!um2ctrl_ack_n);
        if (n > 3) begin
            abort_run("localbus ack stayed low more than three cycles after release");
        end
    endtask

    // mask and action table for one phase, written then read back
    task automatic configure_phase(input logic [2:0] mask_bits);
        logic [31:0] data;
        logic [31:0] rdata;
        data      = $random(seed_pkt);
        data[2:0] = mask_bits;
        cfg_access(1'b0, KEY_ADDR, data, rdata);
        mask_m = data[2:0];
        cfg_access(1'b1, KEY_ADDR, 32'd0, rdata);
        check_value("ctrl_dataout key mask", 160'(rdata), 160'({29'd0, mask_m}));
        for (int i = 0; i < `UM_ACT_DEPTH; i++) begin
            data    = $random(seed_pkt);
            // about one entry in four drops
            data[8] = ({$random(seed_pkt)} % 4) == 0;
            cfg_access(1'b0, {`UM_SEL_ACT, 9'd0, 4'(i)}, data, rdata);
            tbl_m[i] = data[8:0];
        end
        for (int i = 0; i < `UM_ACT_DEPTH; i++) begin
            cfg_access(1'b1, {`UM_SEL_ACT, 9'd0, 4'(i)}, 32'd0, rdata);
            check_value("ctrl_dataout action entry", 160'(rdata), 160'({23'd0, tbl_m[i]}));
        end
    endtask

    //************************************************************
    // packet source
    //************************************************************
    task automatic send_flit(input um_pkg::flit_t f);
        @(negedge clk);
        // random idle cycles, and none while pktin_ready is low
        while (!pktin_ready || ({$random(seed_pkt)} % 8) == 0) begin
            pktin_data_wr = 1'b0;
            @(negedge clk);
        end
        pktin_data    = f;
        pktin_data_wr = 1'b1;
    endtask

    task automatic send_packet();
        um_pkg::flit_t       f;
        um_pkg::flit_t       pkt [$];
        um_pkg::lookup_key_t k;
        um_pkg::act_entry_t  e;
        int                  len;
        len = 2 + int'({$random(seed_pkt)} % (MAX_LEN - 1));
        for (int i = 0; i < len; i++) begin
            if (i == 0) begin
                f.tag = um_pkg::TAG_HEAD;
            end else if (i == len - 1) begin
                f.tag = um_pkg::TAG_TAIL;
            end else begin
                f.tag = um_pkg::TAG_BODY;
            end
            f.inv = (i == len - 1) ? 4'($random(seed_pkt)) : 4'd0;
            for (int w = 0; w < `UM_DATA_W / 32; w++) begin
                f.data.raw[32*w +: 32] = $random(seed_pkt);
            end
            pkt.push_back(f);
        end
        // disabled key fields read as zero
        k.dmac      = pkt[0].data.hdr.dmac & {48{mask_m[0]}};
        k.ethertype = pkt[0].data.hdr.ethertype & {16{mask_m[1]}};
        k.in_port   = pkt[0].data.hdr.in_port & {8{mask_m[2]}};
        exp_key_q.push_back(k);
        e = tbl_m[k.in_port[3:0] ^ k.in_port[7:4]];
        if (!e.drop) begin
            for (int i = 0; i < len; i++) begin
                f = pkt[i];
                if (i == 0) begin
                    f.data.hdr.out_port = e.out_port;
                end
                exp_flit_q.push_back(f);
                exp_total++;
            end
        end
        for (int i = 0; i < len; i++) begin
            send_flit(pkt[i]);
        end
    endtask

    task automatic wait_drained();
        @(negedge clk);
        pktin_data_wr = 1'b0;
        while (exp_key_q.size() != 0 || rsp_key_q.size() != 0 || rx_cnt != exp_total) begin
            @(negedge clk);
        end
        // dropped packets at the end leave no trace on pktout
        repeat (40) @(negedge clk);
    endtask

    //************************************************************
    // match engine, answers keys in order after 1 to 6 cycles
    //************************************************************
    initial begin : match_engine
        int                  delay;
        um_pkg::lookup_key_t k;
        match_id    = '0;
        match_id_wr = 1'b0;
        delay = 1 + int'({$random(seed_rsp)} % 6);
        forever begin
            @(negedge clk);
            match_id_wr = 1'b0;
            if (rsp_key_q.size() != 0) begin
                if (delay > 1) begin
                    delay--;
                end else if (!match_alf) begin
                    k           = rsp_key_q.pop_front();
                    match_id    = `UM_ID_W'(k.in_port[3:0] ^ k.in_port[7:4]);
                    match_id_wr = 1'b1;
                    delay       = 1 + int'({$random(seed_rsp)} % 6);
                end
            end
        end
    end

    // random back-pressure on pktout and the match engine
    initial begin : back_pressure
        pktout_ready = 1'b1;
        match_ready  = 1'b1;
        forever begin
            @(negedge clk);
            if (bp_en) begin
                pktout_ready = ({$random(seed_bp)} % 4) != 0;
                match_ready  = ({$random(seed_bp)} % 2) != 0;
            end else begin
                pktout_ready = 1'b1;
                match_ready  = 1'b1;
            end
        end
    end

    // output monitor, values here are the ones from before the edge
    always @(posedge clk) begin
        if (match_key_wr) begin
            if (exp_key_q.size() == 0) begin
                abort_run("match key issued with no packet waiting for one");
            end else begin
                check_value("match_key", 160'(match_key), 160'(exp_key_q.pop_front()));
                rsp_key_q.push_back(match_key);
            end
        end
        if (pktout_data_wr) begin
            if (!ready_prev) begin
                abort_run("flit sent on pktout after pktout_ready was seen low");
            end else if (exp_flit_q.size() == 0) begin
                abort_run("flit on pktout with no packet expected");
            end else begin
                check_value("pktout_data", 160'(pktout_data), 160'(exp_flit_q.pop_front()));
                rx_cnt++;
            end
        end
        ready_prev = pktout_ready;
    end

    initial begin : watchdog
        #(WD_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired before the test sequence finished");
    end

    //************************************************************
    // test sequence
    //************************************************************
    initial begin : stimulus
        logic [31:0] rdata;
        rst_n         = 1'b0;
        pktin_data    = '0;
        pktin_data_wr = 1'b0;
        ctrl_cs_n     = 1'b1;
        ctrl_cmd      = 1'b0;
        ctrl_addr     = '0;
        ctrl_datain   = '0;
        repeat (8) begin
            @(negedge clk);
            check_reset_outputs(1'b1);
        end
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_reset_outputs(1'b0);
        end
        for (int p = 0; p < N_PHASE; p++) begin
            // first phase runs without back-pressure
            bp_en = (p != 0);
            configure_phase(PHASE_MASK[p]);
            if (p == 0) begin
                cfg_access(1'b1, BAD_ADDR, 32'd0, rdata);
                check_value("ctrl_dataout unmapped", 160'(rdata), 160'(32'd0));
            end
            for (int n = 0; n < PKT_PER_PHASE; n++) begin
                send_packet();
            end
            wait_drained();
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== verilog/um_top.sv ====
//************************************************************
// top level of the packet pipeline, connects parser, key
// builder, action stage, output stage and localbus dispatcher
//************************************************************
`include "um_cfg.svh"

module um_top (
    input  logic                clk,
    input  logic                rst_n,
    input  um_pkg::flit_t       pktin_data,
    input  logic                pktin_data_wr,
    output logic                pktin_ready,
    output um_pkg::flit_t       pktout_data,
    output logic                pktout_data_wr,
    input  logic                pktout_ready,
    output um_pkg::lookup_key_t match_key,
    output logic                match_key_wr,
    input  logic                match_ready,
    input  logic [`UM_ID_W-1:0] match_id,
    input  logic                match_id_wr,
    output logic                match_alf,
    input  logic                ctrl_cs_n,
    input  logic                ctrl_cmd,
    input  logic [31:0]         ctrl_addr,
    input  logic [31:0]         ctrl_datain,
    output logic                um2ctrl_ack_n,
    output logic [31:0]         ctrl_dataout
);

    // parser to key builder
    um_pkg::pkt_hdr_t   hdr;
    logic               hdr_wr;
    logic               hdr_alf;
    // parser to output stage
    um_pkg::flit_t      flit;
    logic               flit_wr;
    logic               flit_alf;
    // action stage to output stage
    um_pkg::act_entry_t act;
    logic               act_wr;
    logic               act_alf;
    // localbus targets
    um_pkg::cfg_req_t   cfg_req;
    logic               key_cs_n;
    logic               key_ack_n;
    logic [31:0]        key_rdata;
    logic               act_cs_n;
    logic               act_ack_n;
    logic [31:0]        act_rdata;

    // all stage ports share the names of the nets above
    cfg_dispatch u_cfg_dispatch (.*);

    pkt_parser u_pkt_parser (.*);

    key_builder u_key_builder (.*);

    action_stage u_action_stage (.*);

    pkt_output u_pkt_output (.*);

endmodule

// ==== verilog/pkt_output.sv ====
//************************************************************
// holds flits until the packet's action arrives, then sends
// the packet with its port rewritten or drains it
//************************************************************
`include "um_cfg.svh"

module pkt_output (
    input  logic               clk,
    input  logic               rst_n,
    input  um_pkg::flit_t      flit,
    input  logic               flit_wr,
    output logic               flit_alf,
    input  um_pkg::act_entry_t act,
    input  logic               act_wr,
    output logic               act_alf,
    output um_pkg::flit_t      pktout_data,
    output logic               pktout_data_wr,
    input  logic               pktout_ready
);

    localparam int FD  = `UM_FLIT_DEPTH;
    localparam int FW  = $clog2(FD);
    localparam int AD  = 2 * `UM_HDR_DEPTH;
    localparam int AAW = $clog2(AD);

    typedef enum logic [1:0] {
        WAIT_S,
        SEND_S,
        DROP_S
    } state_t;

    um_pkg::flit_t      flit_mem [FD];
    logic [FW-1:0]      f_wr_ptr;
    logic [FW-1:0]      f_rd_ptr;
    logic [FW:0]        f_cnt;
    logic               f_pop;
    um_pkg::act_entry_t act_mem [AD];
    logic [AAW-1:0]     a_wr_ptr;
    logic [AAW-1:0]     a_rd_ptr;
    logic [AAW:0]       a_cnt;
    logic               a_pop;
    state_t             state;
    um_pkg::act_entry_t cur_act;
    um_pkg::flit_t      f_head;
    um_pkg::flit_t      f_out;

    //************************************************************
    // fifo levels count the word arriving this cycle
    //************************************************************
    assign flit_alf = (int'(f_cnt) + int'(flit_wr)) >= (FD - `UM_ALF_MARGIN);
    assign act_alf  = (int'(a_cnt) + int'(act_wr)) >= (AD - `UM_ALF_MARGIN);

    assign f_head = flit_mem[f_rd_ptr];
    assign a_pop  = (state == WAIT_S) && (a_cnt != '0);
    assign f_pop  = (f_cnt != '0) && (((state == SEND_S) && pktout_ready) || (state == DROP_S));

    // head flit leaves with the port from its action
    always_comb begin
        f_out = f_head;
        if (f_head.tag == um_pkg::TAG_HEAD) begin
            f_out.data.hdr.out_port = cur_act.out_port;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            f_wr_ptr       <= '0;
            f_rd_ptr       <= '0;
            f_cnt          <= '0;
            a_wr_ptr       <= '0;
            a_rd_ptr       <= '0;
            a_cnt          <= '0;
            state          <= WAIT_S;
            pktout_data_wr <= 1'b0;
        end else begin
            if (flit_wr) begin
                f_wr_ptr <= f_wr_ptr + 1'b1;
            end
            if (f_pop) begin
                f_rd_ptr <= f_rd_ptr + 1'b1;
            end
            if (act_wr) begin
                a_wr_ptr <= a_wr_ptr + 1'b1;
            end
            if (a_pop) begin
                a_rd_ptr <= a_rd_ptr + 1'b1;
            end
            f_cnt          <= f_cnt + (FW+1)'(flit_wr) - (FW+1)'(f_pop);
            a_cnt          <= a_cnt + (AAW+1)'(act_wr) - (AAW+1)'(a_pop);
            pktout_data_wr <= f_pop && (state == SEND_S);
            case (state)
                WAIT_S: begin
                    if (a_pop) begin
                        state <= act_mem[a_rd_ptr].drop ? DROP_S : SEND_S;
                    end
                end
                SEND_S, DROP_S: begin
                    if (f_pop && (f_head.tag == um_pkg::TAG_TAIL)) begin
                        state <= WAIT_S;
                    end
                end
                default: state <= WAIT_S;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (flit_wr) begin
            flit_mem[f_wr_ptr] <= flit;
        end
        if (act_wr) begin
            act_mem[a_wr_ptr] <= act;
        end
        if (a_pop) begin
            cur_act <= act_mem[a_rd_ptr];
        end
        if (f_pop && (state == SEND_S)) begin
            pktout_data <= f_out;
        end
    end

    // upstream stages honor the almost full levels
    assert property (@(posedge clk) disable iff (!rst_n) flit_wr |-> int'(f_cnt) < FD);
    assert property (@(posedge clk) disable iff (!rst_n) act_wr |-> int'(a_cnt) < AD);

endmodule

// ==== verilog/action_stage.sv ====
//************************************************************
// queues rule ids from the match engine and looks each one up
// in the localbus-writable action table
//************************************************************
`include "um_cfg.svh"

module action_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`UM_ID_W-1:0] match_id,
    input  logic               match_id_wr,
    output logic               match_alf,
    output um_pkg::act_entry_t act,
    output logic               act_wr,
    input  logic               act_alf,
    input  um_pkg::cfg_req_t   cfg_req,
    input  logic               act_cs_n,
    output logic               act_ack_n,
    output logic [31:0]        act_rdata
);

    // room for every header the key builder can hold, twice
    localparam int DEPTH = 2 * `UM_HDR_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int TW    = $clog2(`UM_ACT_DEPTH);

    logic [`UM_ID_W-1:0] id_mem [DEPTH];
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic [AW:0]         cnt;
    logic                pop;
    um_pkg::act_entry_t  act_tbl [`UM_ACT_DEPTH];
    logic [TW-1:0]       head_idx;
    logic [TW-1:0]       cfg_idx;

    assign pop       = (cnt != '0) && !act_alf;
    assign match_alf = int'(cnt) >= (DEPTH - `UM_ALF_MARGIN);
    assign head_idx  = id_mem[rd_ptr][TW-1:0];
    assign cfg_idx   = cfg_req.addr[TW-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            cnt       <= '0;
            act_wr    <= 1'b0;
            act_ack_n <= 1'b1;
            for (int i = 0; i < `UM_ACT_DEPTH; i++) begin
                act_tbl[i] <= '0;
            end
        end else begin
            if (match_id_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            cnt       <= cnt + (AW+1)'(match_id_wr) - (AW+1)'(pop);
            act_wr    <= pop;
            act_ack_n <= act_cs_n;
            // data bit 8 is drop, bits 7:0 out_port
            if (!act_cs_n && act_ack_n && !cfg_req.rw) begin
                act_tbl[cfg_idx] <= um_pkg::act_entry_t'(cfg_req.wdata[8:0]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (match_id_wr) begin
            id_mem[wr_ptr] <= match_id;
        end
        if (pop) begin
            act <= act_tbl[head_idx];
        end
        if (!act_cs_n) begin
            act_rdata <= {23'b0, act_tbl[cfg_idx]};
        end
    end

endmodule

// ==== verilog/key_builder.sv ====
//************************************************************
// queues parsed headers and issues masked lookup keys to the
// match engine, the field mask sits on the localbus
//************************************************************
`include "um_cfg.svh"

module key_builder (
    input  logic                clk,
    input  logic                rst_n,
    input  um_pkg::pkt_hdr_t    hdr,
    input  logic                hdr_wr,
    output logic                hdr_alf,
    output um_pkg::lookup_key_t match_key,
    output logic                match_key_wr,
    input  logic                match_ready,
    input  um_pkg::cfg_req_t    cfg_req,
    input  logic                key_cs_n,
    output logic                key_ack_n,
    output logic [31:0]         key_rdata
);

    localparam int DEPTH = `UM_HDR_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    um_pkg::pkt_hdr_t    hdr_mem [DEPTH];
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic [AW:0]         cnt;
    logic                pop;
    logic [2:0]          mask_q;
    logic                cfg_hit;
    logic [`UM_KEY_W-1:0] key_mask;
    um_pkg::pkt_hdr_t    head;
    um_pkg::lookup_key_t key_raw;

    assign head     = hdr_mem[rd_ptr];
    assign key_raw  = '{dmac: head.dmac, ethertype: head.ethertype, in_port: head.in_port};
    // mask bit 0 dmac, bit 1 ethertype, bit 2 in_port
    assign key_mask = {{48{mask_q[0]}}, {16{mask_q[1]}}, {8{mask_q[2]}}};
    assign match_key = um_pkg::lookup_key_t'(key_raw & key_mask);

    assign pop          = (cnt != '0) && match_ready;
    assign match_key_wr = pop;
    assign hdr_alf      = (int'(cnt) + int'(hdr_wr)) >= (DEPTH - `UM_ALF_MARGIN);
    assign cfg_hit      = (cfg_req.addr[12:0] == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            cnt       <= '0;
            mask_q    <= 3'b111;
            key_ack_n <= 1'b1;
        end else begin
            if (hdr_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            cnt       <= cnt + (AW+1)'(hdr_wr) - (AW+1)'(pop);
            key_ack_n <= key_cs_n;
            // write on the first select cycle only
            if (!key_cs_n && key_ack_n && !cfg_req.rw && cfg_hit) begin
                mask_q <= cfg_req.wdata[2:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_wr) begin
            hdr_mem[wr_ptr] <= hdr;
        end
        if (!key_cs_n) begin
            key_rdata <= cfg_hit ? {29'b0, mask_q} : '0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) match_key_wr |-> match_ready);
    // parser honors hdr_alf
    assert property (@(posedge clk) disable iff (!rst_n) hdr_wr |-> int'(cnt) < DEPTH);

endmodule

// ==== verilog/pkt_parser.sv ====
//************************************************************
// input stage, registers flits toward the output stage and
// extracts one header per packet from its head flit
//************************************************************

module pkt_parser (
    input  logic             clk,
    input  logic             rst_n,
    input  um_pkg::flit_t    pktin_data,
    input  logic             pktin_data_wr,
    output logic             pktin_ready,
    output um_pkg::pkt_hdr_t hdr,
    output logic             hdr_wr,
    input  logic             hdr_alf,
    output um_pkg::flit_t    flit,
    output logic             flit_wr,
    input  logic             flit_alf
);

    logic run_q;
    logic in_pkt;
    logic is_head;
    logic is_tail;

    assign is_head = pktin_data_wr && (pktin_data.tag == um_pkg::TAG_HEAD);
    assign is_tail = pktin_data_wr && (pktin_data.tag == um_pkg::TAG_TAIL);

    // downstream levels already count the word held here
    assign pktin_ready = run_q && !hdr_alf && !flit_alf;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q   <= 1'b0;
            in_pkt  <= 1'b0;
            hdr_wr  <= 1'b0;
            flit_wr <= 1'b0;
        end else begin
            run_q   <= 1'b1;
            hdr_wr  <= is_head;
            flit_wr <= pktin_data_wr;
            if (is_head) begin
                in_pkt <= 1'b1;
            end else if (is_tail) begin
                in_pkt <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pktin_data_wr) begin
            flit <= pktin_data;
        end
        if (is_head) begin
            hdr <= pktin_data.data.hdr;
        end
    end

    // packets are framed head to tail with no overlap
    assert property (@(posedge clk) disable iff (!rst_n) is_head |-> !in_pkt);
    assert property (@(posedge clk) disable iff (!rst_n)
        (pktin_data_wr && !is_head) |-> in_pkt);

endmodule

// ==== verilog/cfg_dispatch.sv ====
//************************************************************
// localbus dispatcher, synchronizes the host chip select and
// forwards each request to the sub-block at address 15:13
//************************************************************
`include "um_cfg.svh"

module cfg_dispatch (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ctrl_cs_n,
    input  logic             ctrl_cmd,
    input  logic [31:0]      ctrl_addr,
    input  logic [31:0]      ctrl_datain,
    output logic             um2ctrl_ack_n,
    output logic [31:0]      ctrl_dataout,
    output um_pkg::cfg_req_t cfg_req,
    output logic             key_cs_n,
    output logic             act_cs_n,
    input  logic             key_ack_n,
    input  logic             act_ack_n,
    input  logic [31:0]      key_rdata,
    input  logic [31:0]      act_rdata
);

    typedef enum logic [1:0] {
        IDLE_S,
        PARSE_S,
        WAIT_ACK_S,
        RELEASE_S
    } state_t;

    state_t state;
    logic   cs_meta;
    logic   cs_sync;
    logic   accept;
    logic   sel_key;
    logic   sel_act;
    logic   key_done;
    logic   act_done;

    // a new request waits until both targets have dropped their ack
    assign accept   = (state == IDLE_S) && cs_sync && key_ack_n && act_ack_n;
    assign sel_key  = (cfg_req.addr[15:13] == `UM_SEL_KEY);
    assign sel_act  = (cfg_req.addr[15:13] == `UM_SEL_ACT);
    assign key_done = !key_cs_n && !key_ack_n;
    assign act_done = !act_cs_n && !act_ack_n;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_meta       <= 1'b0;
            cs_sync       <= 1'b0;
            state         <= IDLE_S;
            um2ctrl_ack_n <= 1'b1;
            key_cs_n      <= 1'b1;
            act_cs_n      <= 1'b1;
        end else begin
            cs_meta <= ~ctrl_cs_n;
            cs_sync <= cs_meta;
            case (state)
                IDLE_S: begin
                    um2ctrl_ack_n <= 1'b1;
                    if (accept) begin
                        state <= PARSE_S;
                    end
                end
                PARSE_S: begin
                    key_cs_n <= !sel_key;
                    act_cs_n <= !sel_act;
                    // unmapped regions skip the target handshake
                    state    <= (sel_key || sel_act) ? WAIT_ACK_S : RELEASE_S;
                end
                WAIT_ACK_S: begin
                    if (key_done || act_done) begin
                        key_cs_n <= 1'b1;
                        act_cs_n <= 1'b1;
                        state    <= RELEASE_S;
                    end
                end
                RELEASE_S: begin
                    um2ctrl_ack_n <= !cs_sync;
                    if (!cs_sync) begin
                        state <= IDLE_S;
                    end
                end
                default: state <= IDLE_S;
            endcase
        end
    end

    // request latch and read data capture
    always_ff @(posedge clk) begin
        if (accept) begin
            cfg_req <= '{rw: ctrl_cmd, addr: ctrl_addr[15:0], wdata: ctrl_datain};
        end
        if (state == PARSE_S && !sel_key && !sel_act) begin
            ctrl_dataout <= '0;
        end else if (state == WAIT_ACK_S && key_done) begin
            ctrl_dataout <= key_rdata;
        end else if (state == WAIT_ACK_S && act_done) begin
            ctrl_dataout <= act_rdata;
        end
    end

    // one target per request
    assert property (@(posedge clk) disable iff (!rst_n) key_cs_n || act_cs_n);

endmodule

// ==== verilog/um_pkg.sv ====
//************************************************************
// shared types of the packet pipeline
// referenced from the RTL and testbench as um_pkg::name
//************************************************************
`include "um_cfg.svh"

package um_pkg;

    typedef enum logic [1:0] {
        TAG_HEAD = 2'b01,
        TAG_BODY = 2'b11,
        TAG_TAIL = 2'b10
    } flit_tag_t;

    // ethernet header carried in the head flit
    typedef struct packed {
        logic [47:0] dmac;
        logic [47:0] smac;
        logic [15:0] ethertype;
        logic [7:0]  in_port;
        logic [7:0]  out_port;
    } pkt_hdr_t;

    // head flit data is a header, other flits are raw payload
    typedef union packed {
        logic [`UM_DATA_W-1:0] raw;
        pkt_hdr_t              hdr;
    } flit_data_u;

    typedef struct packed {
        flit_tag_t  tag;
        logic [3:0] inv;
        flit_data_u data;
    } flit_t;

    typedef struct packed {
        logic [47:0] dmac;
        logic [15:0] ethertype;
        logic [7:0]  in_port;
    } lookup_key_t;

    typedef struct packed {
        logic       drop;
        logic [7:0] out_port;
    } act_entry_t;

    // rw is 0 for write, 1 for read
    typedef struct packed {
        logic        rw;
        logic [15:0] addr;
        logic [31:0] wdata;
    } cfg_req_t;

endpackage

// ==== verilog/um_cfg.svh ====
//************************************************************
// sizes and localbus address map of the packet pipeline
// included by the package and by every RTL file that needs them
//************************************************************
`ifndef UM_CFG_SVH
`define UM_CFG_SVH

// datapath widths
`define UM_DATA_W      128
`define UM_KEY_W       72
`define UM_ID_W        16

// storage depths
`define UM_ACT_DEPTH   16
`define UM_FLIT_DEPTH  64
`define UM_HDR_DEPTH   8
// free slots left when a fifo raises almost full
`define UM_ALF_MARGIN  4

// localbus regions, address bits 15:13
`define UM_SEL_KEY     3'b010
`define UM_SEL_ACT     3'b100

`endif
